//--- build.f
verilog/bus_pkg.sv
verilog/mem_op_pkg.sv
verilog/fetch_port.sv
verilog/lsu_port.sv
verilog/bus_arbiter.sv
verilog/mem_access_top.sv
testbench/axi_lite_mem_model.sv
testbench/tb_mem_access.sv

//--- Bender.yml
package:
  name: mem_access

sources:
  - verilog/bus_pkg.sv
  - verilog/mem_op_pkg.sv
  - verilog/fetch_port.sv
  - verilog/lsu_port.sv
  - verilog/bus_arbiter.sv
  - verilog/mem_access_top.sv
  - target: test
    files:
      - testbench/axi_lite_mem_model.sv
      - testbench/tb_mem_access.sv

//--- testbench/tb_mem_access.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_access;
  import bus_pkg::*;
  import mem_op_pkg::*;

  localparam int n_trans    = 30;
  localparam int max_cycles = 40 * n_trans + 16;
  localparam logic [addr_width-1:0] err_base = 32'h0000_f000;

  logic                  clk, rst;
  logic                  fetch_valid, fetch_ready, fetch_rsp_valid, fetch_err;
  logic [addr_width-1:0] fetch_pc;
  logic [inst_width-1:0] fetch_inst;
  logic                  lsu_valid, lsu_ready, lsu_rsp_valid, lsu_err;
  mem_op_e               lsu_op;
  logic [addr_width-1:0] lsu_addr;
  logic [xlen-1:0]       lsu_wdata, lsu_rdata;
  logic                  awvalid, awready, wvalid, wready, bvalid, bready;
  logic                  arvalid, arready, rvalid, rready;
  logic [addr_width-1:0] awaddr, araddr;
  logic [data_width-1:0] wdata, rdata;
  logic [strb_width-1:0] wstrb;
  logic [1:0]            bresp, rresp;
  logic                  quiet;

  logic [data_width-1:0] ref_mem [0:8191];
  logic [xlen-1:0]       lsu_exp_data;
  logic [inst_width-1:0] fetch_exp_inst;
  logic                  lsu_exp_err, fetch_exp_err;
  logic                  order_check = 1'b0;
  int lsu_req_cnt = 0;
  int lsu_rsp_cnt = 0;
  int fetch_req_cnt = 0;
  int fetch_rsp_cnt = 0;
  int errors = 0;
  int cycles = 0;

  mem_op_e             load_ops [0:6] = '{LB, LBU, LH, LHU, LW, LWU, LD};
  logic [addr_width-1:0] load_addrs [0:6] =
    '{32'h117, 32'h107, 32'h112, 32'h106, 32'h10c, 32'h104, 32'h108};

  mem_access_top i_mem_access_top (
    .clk (clk), .rst (rst),
    .fetch_valid_i (fetch_valid), .fetch_pc_i (fetch_pc), .fetch_ready_o (fetch_ready),
    .fetch_rsp_valid_o (fetch_rsp_valid), .fetch_inst_o (fetch_inst), .fetch_err_o (fetch_err),
    .lsu_valid_i (lsu_valid), .lsu_op_i (lsu_op), .lsu_addr_i (lsu_addr),
    .lsu_wdata_i (lsu_wdata), .lsu_ready_o (lsu_ready), .lsu_rsp_valid_o (lsu_rsp_valid),
    .lsu_rdata_o (lsu_rdata), .lsu_err_o (lsu_err),
    .m_awvalid_o (awvalid), .m_awready_i (awready), .m_awaddr_o (awaddr),
    .m_wvalid_o (wvalid), .m_wready_i (wready), .m_wdata_o (wdata), .m_wstrb_o (wstrb),
    .m_bvalid_i (bvalid), .m_bready_o (bready), .m_bresp_i (bresp),
    .m_arvalid_o (arvalid), .m_arready_i (arready), .m_araddr_o (araddr),
    .m_rvalid_i (rvalid), .m_rready_o (rready), .m_rdata_i (rdata), .m_rresp_i (rresp)
  );

  axi_lite_mem_model i_axi_lite_mem_model (
    .clk (clk), .rst (rst),
    .awvalid_i (awvalid), .awready_o (awready), .awaddr_i (awaddr),
    .wvalid_i (wvalid), .wready_o (wready), .wdata_i (wdata), .wstrb_i (wstrb),
    .bvalid_o (bvalid), .bready_i (bready), .bresp_o (bresp),
    .arvalid_i (arvalid), .arready_o (arready), .araddr_i (araddr),
    .rvalid_o (rvalid), .rready_i (rready), .rdata_o (rdata), .rresp_o (rresp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  assign quiet = !awvalid && !wvalid && !arvalid && !bready && !rready &&
                 !fetch_rsp_valid && !lsu_rsp_valid && fetch_ready && lsu_ready;

  assert property (@(posedge clk) rst |=> quiet)
    else begin
      errors++;
      $display("bus or client outputs not idle in reset at %0t", $time);
    end

  // valids held with steady payload until ready
  assert property (@(posedge clk) disable iff (rst)
      awvalid && !awready |=> awvalid && $stable(awaddr))
    else begin
      errors++;
      $display("aw channel changed before awready at %0t", $time);
    end
  assert property (@(posedge clk) disable iff (rst)
      wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
    else begin
      errors++;
      $display("w channel changed before wready at %0t", $time);
    end
  assert property (@(posedge clk) disable iff (rst)
      arvalid && !arready |=> arvalid && $stable(araddr))
    else begin
      errors++;
      $display("ar channel changed before arready at %0t", $time);
    end

  // bus addresses are word aligned
  assert property (@(posedge clk) disable iff (rst) awvalid |-> awaddr[2:0] == 3'b000)
    else begin
      errors++;
      $display("Fail %0t: awaddr %h has low bits set", $time, $sampled(awaddr));
    end
  assert property (@(posedge clk) disable iff (rst) arvalid |-> araddr[2:0] == 3'b000)
    else begin
      errors++;
      $display("Fail %0t: araddr %h has low bits set", $time, $sampled(araddr));
    end

  // client ready low from acceptance through the response pulse
  assert property (@(posedge clk) disable iff (rst) lsu_valid && lsu_ready |=> !lsu_ready)
    else begin
      errors++;
      $display("lsu ready still high after accept at %0t", $time);
    end
  assert property (@(posedge clk) disable iff (rst) !lsu_ready && !lsu_rsp_valid |=> !lsu_ready)
    else begin
      errors++;
      $display("lsu ready rose before its response at %0t", $time);
    end
  assert property (@(posedge clk) disable iff (rst) lsu_rsp_valid |-> !lsu_ready ##1 lsu_ready)
    else begin
      errors++;
      $display("lsu ready wrong around response at %0t", $time);
    end
  assert property (@(posedge clk) disable iff (rst) fetch_valid && fetch_ready |=> !fetch_ready)
    else begin
      errors++;
      $display("fetch ready still high after accept at %0t", $time);
    end
  assert property (@(posedge clk) disable iff (rst)
      !fetch_ready && !fetch_rsp_valid |=> !fetch_ready)
    else begin
      errors++;
      $display("fetch ready rose before its response at %0t", $time);
    end
  assert property (@(posedge clk) disable iff (rst)
      fetch_rsp_valid |-> !fetch_ready ##1 fetch_ready)
    else begin
      errors++;
      $display("fetch ready wrong around response at %0t", $time);
    end

  assert property (@(posedge clk) disable iff (rst)
      lsu_rsp_valid |-> lsu_err == lsu_exp_err && (lsu_exp_err || lsu_rdata == lsu_exp_data))
    else begin
      errors++;
      $display("Fail %0t: lsu data %h err %b, expected %h err %b", $time,
               $sampled(lsu_rdata), $sampled(lsu_err), lsu_exp_data, lsu_exp_err);
    end
  assert property (@(posedge clk) disable iff (rst)
      fetch_rsp_valid |-> fetch_err == fetch_exp_err &&
                          (fetch_exp_err || fetch_inst == fetch_exp_inst))
    else begin
      errors++;
      $display("Fail %0t: fetch inst %h err %b, expected %h err %b", $time,
               $sampled(fetch_inst), $sampled(fetch_err), fetch_exp_inst, fetch_exp_err);
    end
  assert property (@(posedge clk) disable iff (rst)
      order_check && fetch_rsp_valid |-> lsu_rsp_cnt == lsu_req_cnt)
    else begin
      errors++;
      $display("fetch answered before load/store at %0t", $time);
    end

  always @(posedge clk) begin
    if (lsu_rsp_valid) lsu_rsp_cnt <= lsu_rsp_cnt + 1;
    if (fetch_rsp_valid) fetch_rsp_cnt <= fetch_rsp_cnt + 1;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic logic [data_width-1:0] image_word(input logic [addr_width-1:0] a);
    return {~(a + 32'd4), a ^ 32'h8765_4321};
  endfunction

  function automatic int op_bytes(input mem_op_e op);
    case (op)
      LB, LBU, SB: return 1;
      LH, LHU, SH: return 2;
      LW, LWU, SW: return 4;
      default: return 8;
    endcase
  endfunction

  function automatic logic [xlen-1:0] load_expect(input mem_op_e op, input logic [2:0] off,
                                                  input logic [data_width-1:0] word);
    int              nbytes;
    logic [xlen-1:0] mask;
    logic [xlen-1:0] v;
    nbytes = op_bytes(op);
    mask   = (nbytes == 8) ? '1 : (64'd1 << (8 * nbytes)) - 64'd1;
    v      = (word >> (8 * off)) & mask;
    if ((op == LB || op == LH || op == LW) && v[8 * nbytes - 1]) v = v | ~mask;
    return v;
  endfunction

  task automatic lsu_drive(input mem_op_e op, input logic [addr_width-1:0] addr,
                           input logic [xlen-1:0] wd);
    int nbytes;
    nbytes       = op_bytes(op);
    lsu_exp_err  = (addr >= err_base);
    lsu_exp_data = '0;
    if (op inside {SB, SH, SW, SD}) begin
      if (!lsu_exp_err) begin
        for (int b = 0; b < nbytes; b++) begin
          ref_mem[addr[15:3]][8 * (addr[2:0] + b) +: 8] = wd[8 * b +: 8];
        end
      end
    end else begin
      lsu_exp_data = load_expect(op, addr[2:0], ref_mem[addr[15:3]]);
    end
    if (!lsu_ready) begin
      errors++;
      $display("lsu port not ready for a new request at %0t", $time);
    end
    lsu_op    = op;
    lsu_addr  = addr;
    lsu_wdata = wd;
    lsu_valid = 1'b1;
    lsu_req_cnt++;
  endtask

  task automatic fetch_drive(input logic [addr_width-1:0] pc);
    logic [data_width-1:0] word;
    word           = ref_mem[pc[15:3]];
    fetch_exp_inst = pc[2] ? word[63:32] : word[31:0];
    fetch_exp_err  = (pc >= err_base);
    if (!fetch_ready) begin
      errors++;
      $display("fetch port not ready for a new request at %0t", $time);
    end
    fetch_pc    = pc;
    fetch_valid = 1'b1;
    fetch_req_cnt++;
  endtask

  // accept edge followed by a wait for every open response
  task automatic step_and_wait;
    @(posedge clk);
    #10;
    lsu_valid   = 1'b0;
    fetch_valid = 1'b0;
    while (lsu_rsp_cnt != lsu_req_cnt || fetch_rsp_cnt != fetch_req_cnt) begin
      @(posedge clk);
      #10;
    end
  endtask

  initial begin
    rst         = 1'b1;
    fetch_valid = 1'b0;
    fetch_pc    = '0;
    lsu_valid   = 1'b0;
    lsu_op      = LD;
    lsu_addr    = '0;
    lsu_wdata   = '0;
    for (int i = 0; i < 8192; i++) begin
      ref_mem[i] = image_word(i * 8);
    end
    repeat (16) @(posedge clk);
    #10;
    rst = 1'b0;

    lsu_drive(SD, 32'h100, 64'hf1e2_d3c4_b5a6_9788);
    step_and_wait();
    lsu_drive(SW, 32'h10c, 64'h1234_5678_8bad_f00d);
    step_and_wait();
    lsu_drive(SH, 32'h112, 64'hffff_0000_5555_9abc);
    step_and_wait();
    lsu_drive(SB, 32'h117, 64'h0000_0000_0000_77c5);
    step_and_wait();
    for (int i = 0; i < 7; i++) begin
      lsu_drive(load_ops[i], load_addrs[i], '0);
      step_and_wait();
      lsu_drive(load_ops[i], 32'h100, '0);
      step_and_wait();
    end
    // bytes around the narrow stores stay untouched
    lsu_drive(LD, 32'h110, '0);
    step_and_wait();

    fetch_drive(32'h200);
    step_and_wait();
    fetch_drive(32'h204);
    step_and_wait();
    fetch_drive(32'h10c);
    step_and_wait();

    // same-cycle requests with load/store answering first
    order_check = 1'b1;
    fetch_drive(32'h310);
    lsu_drive(LW, 32'h104, '0);
    step_and_wait();
    fetch_drive(32'h314);
    lsu_drive(SD, 32'h320, 64'h8000_0000_0000_0001);
    step_and_wait();
    order_check = 1'b0;
    lsu_drive(LD, 32'h320, '0);
    step_and_wait();

    lsu_drive(LD, 32'hf000, '0);
    step_and_wait();
    lsu_drive(SW, 32'hf804, 64'h0000_0000_dead_beef);
    step_and_wait();
    fetch_drive(32'hfff4);
    step_and_wait();

    repeat (4) @(posedge clk);
    $display("lsu responses %0d, fetch responses %0d, errors %0d",
             lsu_rsp_cnt, fetch_rsp_cnt, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/axi_lite_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_mem_model (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           awvalid_i,
  output logic                           awready_o,
  input  logic [bus_pkg::addr_width-1:0] awaddr_i,
  input  logic                           wvalid_i,
  output logic                           wready_o,
  input  logic [bus_pkg::data_width-1:0] wdata_i,
  input  logic [bus_pkg::strb_width-1:0] wstrb_i,
  output logic                           bvalid_o,
  input  logic                           bready_i,
  output logic [1:0]                     bresp_o,
  input  logic                           arvalid_i,
  output logic                           arready_o,
  input  logic [bus_pkg::addr_width-1:0] araddr_i,
  output logic                           rvalid_o,
  input  logic                           rready_i,
  output logic [bus_pkg::data_width-1:0] rdata_o,
  output logic [1:0]                     rresp_o
);
  import bus_pkg::*;

  localparam logic [addr_width-1:0] err_base = 32'h0000_f000;

  logic [data_width-1:0] mem [0:8191];
  integer                seed = 32'hdfc3_cf39;
  logic [1:0]            aw_wait, w_wait, ar_wait;
  logic                  aw_got, w_got, ar_got;
  logic [addr_width-1:0] aw_addr, ar_addr;
  logic [data_width-1:0] w_data;
  logic [strb_width-1:0] w_strb;

  // fill word from the full byte address
  function automatic logic [data_width-1:0] fill_word(input logic [addr_width-1:0] a);
    return {~(a + 32'd4), a ^ 32'h8765_4321};
  endfunction

  initial begin
    for (int i = 0; i < 8192; i++) begin
      mem[i] = fill_word(i * 8);
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      arready_o <= 1'b0;
      bvalid_o  <= 1'b0;
      rvalid_o  <= 1'b0;
      bresp_o   <= OKAY;
      rresp_o   <= OKAY;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
      ar_got    <= 1'b0;
      aw_wait   <= 2'($random(seed));
      w_wait    <= 2'($random(seed));
      ar_wait   <= 2'($random(seed));
    end else begin
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      arready_o <= 1'b0;
      // ready goes up after 0 to 3 idle cycles with valid seen
      if (awready_o) begin
        aw_addr <= awaddr_i;
        aw_got  <= 1'b1;
      end else if (awvalid_i && !aw_got) begin
        awready_o <= (aw_wait == 2'd0);
        aw_wait   <= (aw_wait == 2'd0) ? 2'($random(seed)) : aw_wait - 2'd1;
      end
      if (wready_o) begin
        w_data <= wdata_i;
        w_strb <= wstrb_i;
        w_got  <= 1'b1;
      end else if (wvalid_i && !w_got) begin
        wready_o <= (w_wait == 2'd0);
        w_wait   <= (w_wait == 2'd0) ? 2'($random(seed)) : w_wait - 2'd1;
      end
      if (arready_o) begin
        ar_addr <= araddr_i;
        ar_got  <= 1'b1;
      end else if (arvalid_i && !ar_got) begin
        arready_o <= (ar_wait == 2'd0);
        ar_wait   <= (ar_wait == 2'd0) ? 2'($random(seed)) : ar_wait - 2'd1;
      end
      // write lands once both address and data are in
      if (aw_got && w_got && !bvalid_o) begin
        aw_got   <= 1'b0;
        w_got    <= 1'b0;
        bvalid_o <= 1'b1;
        bresp_o  <= (aw_addr >= err_base) ? SLVERR : OKAY;
        if (aw_addr < err_base) begin
          for (int i = 0; i < strb_width; i++) begin
            if (w_strb[i]) mem[aw_addr[15:3]][8*i +: 8] <= w_data[8*i +: 8];
          end
        end
      end else if (bvalid_o && bready_i) begin
        bvalid_o <= 1'b0;
      end
      if (ar_got && !rvalid_o) begin
        ar_got   <= 1'b0;
        rvalid_o <= 1'b1;
        rdata_o  <= (ar_addr < err_base) ? mem[ar_addr[15:3]] : '0;
        rresp_o  <= (ar_addr < err_base) ? OKAY : SLVERR;
      end else if (rvalid_o && rready_i) begin
        rvalid_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/mem_access_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_top (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             fetch_valid_i,
  input  logic [bus_pkg::addr_width-1:0]   fetch_pc_i,
  output logic                             fetch_ready_o,
  output logic                             fetch_rsp_valid_o,
  output logic [mem_op_pkg::inst_width-1:0] fetch_inst_o,
  output logic                             fetch_err_o,
  input  logic                             lsu_valid_i,
  input  mem_op_pkg::mem_op_e              lsu_op_i,
  input  logic [bus_pkg::addr_width-1:0]   lsu_addr_i,
  input  logic [mem_op_pkg::xlen-1:0]      lsu_wdata_i,
  output logic                             lsu_ready_o,
  output logic                             lsu_rsp_valid_o,
  output logic [mem_op_pkg::xlen-1:0]      lsu_rdata_o,
  output logic                             lsu_err_o,
  output logic                             m_awvalid_o,
  input  logic                             m_awready_i,
  output logic [bus_pkg::addr_width-1:0]   m_awaddr_o,
  output logic                             m_wvalid_o,
  input  logic                             m_wready_i,
  output logic [bus_pkg::data_width-1:0]   m_wdata_o,
  output logic [bus_pkg::strb_width-1:0]   m_wstrb_o,
  input  logic                             m_bvalid_i,
  output logic                             m_bready_o,
  input  logic [1:0]                       m_bresp_i,
  output logic                             m_arvalid_o,
  input  logic                             m_arready_i,
  output logic [bus_pkg::addr_width-1:0]   m_araddr_o,
  input  logic                             m_rvalid_i,
  output logic                             m_rready_o,
  input  logic [bus_pkg::data_width-1:0]   m_rdata_i,
  input  logic [1:0]                       m_rresp_i
);
  import bus_pkg::*;

  logic                  f_req;
  logic [addr_width-1:0] f_addr;
  logic                  f_done;
  logic                  d_req;
  logic                  d_we;
  logic [addr_width-1:0] d_addr;
  logic [data_width-1:0] d_wdata;
  logic [strb_width-1:0] d_wstrb;
  logic                  d_done;
  logic [data_width-1:0] bus_rdata;
  logic                  bus_err;

  fetch_port i_fetch_port (
    .clk               (clk),
    .rst               (rst),
    .fetch_valid_i     (fetch_valid_i),
    .fetch_pc_i        (fetch_pc_i),
    .fetch_ready_o     (fetch_ready_o),
    .fetch_rsp_valid_o (fetch_rsp_valid_o),
    .fetch_inst_o      (fetch_inst_o),
    .fetch_err_o       (fetch_err_o),
    .f_req_o           (f_req),
    .f_addr_o          (f_addr),
    .f_done_i          (f_done),
    .bus_rdata_i       (bus_rdata),
    .bus_err_i         (bus_err)
  );

  lsu_port i_lsu_port (
    .clk             (clk),
    .rst             (rst),
    .lsu_valid_i     (lsu_valid_i),
    .lsu_op_i        (lsu_op_i),
    .lsu_addr_i      (lsu_addr_i),
    .lsu_wdata_i     (lsu_wdata_i),
    .lsu_ready_o     (lsu_ready_o),
    .lsu_rsp_valid_o (lsu_rsp_valid_o),
    .lsu_rdata_o     (lsu_rdata_o),
    .lsu_err_o       (lsu_err_o),
    .d_req_o         (d_req),
    .d_we_o          (d_we),
    .d_addr_o        (d_addr),
    .d_wdata_o       (d_wdata),
    .d_wstrb_o       (d_wstrb),
    .d_done_i        (d_done),
    .bus_rdata_i     (bus_rdata),
    .bus_err_i       (bus_err)
  );

  bus_arbiter i_bus_arbiter (
    .clk         (clk),
    .rst         (rst),
    .f_req_i     (f_req),
    .f_addr_i    (f_addr),
    .d_req_i     (d_req),
    .d_we_i      (d_we),
    .d_addr_i    (d_addr),
    .d_wdata_i   (d_wdata),
    .d_wstrb_i   (d_wstrb),
    .f_done_o    (f_done),
    .d_done_o    (d_done),
    .bus_rdata_o (bus_rdata),
    .bus_err_o   (bus_err),
    .m_awvalid_o (m_awvalid_o),
    .m_awready_i (m_awready_i),
    .m_awaddr_o  (m_awaddr_o),
    .m_wvalid_o  (m_wvalid_o),
    .m_wready_i  (m_wready_i),
    .m_wdata_o   (m_wdata_o),
    .m_wstrb_o   (m_wstrb_o),
    .m_bvalid_i  (m_bvalid_i),
    .m_bready_o  (m_bready_o),
    .m_bresp_i   (m_bresp_i),
    .m_arvalid_o (m_arvalid_o),
    .m_arready_i (m_arready_i),
    .m_araddr_o  (m_araddr_o),
    .m_rvalid_i  (m_rvalid_i),
    .m_rready_o  (m_rready_o),
    .m_rdata_i   (m_rdata_i),
    .m_rresp_i   (m_rresp_i)
  );

endmodule

`default_nettype wire

//--- verilog/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           f_req_i,
  input  logic [bus_pkg::addr_width-1:0] f_addr_i,
  input  logic                           d_req_i,
  input  logic                           d_we_i,
  input  logic [bus_pkg::addr_width-1:0] d_addr_i,
  input  logic [bus_pkg::data_width-1:0] d_wdata_i,
  input  logic [bus_pkg::strb_width-1:0] d_wstrb_i,
  output logic                           f_done_o,
  output logic                           d_done_o,
  output logic [bus_pkg::data_width-1:0] bus_rdata_o,
  output logic                           bus_err_o,
  output logic                           m_awvalid_o,
  input  logic                           m_awready_i,
  output logic [bus_pkg::addr_width-1:0] m_awaddr_o,
  output logic                           m_wvalid_o,
  input  logic                           m_wready_i,
  output logic [bus_pkg::data_width-1:0] m_wdata_o,
  output logic [bus_pkg::strb_width-1:0] m_wstrb_o,
  input  logic                           m_bvalid_i,
  output logic                           m_bready_o,
  input  logic [1:0]                     m_bresp_i,
  output logic                           m_arvalid_o,
  input  logic                           m_arready_i,
  output logic [bus_pkg::addr_width-1:0] m_araddr_o,
  input  logic                           m_rvalid_i,
  output logic                           m_rready_o,
  input  logic [bus_pkg::data_width-1:0] m_rdata_i,
  input  logic [1:0]                     m_rresp_i
);
  import bus_pkg::*;

  arb_state_e            state_q;
  logic                  grant_d_q;
  logic                  awvalid_q;
  logic                  wvalid_q;
  logic                  arvalid_q;
  logic [addr_width-1:0] addr_q;
  logic [data_width-1:0] wdata_q;
  logic [strb_width-1:0] wstrb_q;
  logic                  aw_done;
  logic                  w_done;
  logic                  rsp_hs;

  // each write channel is finished once its valid is gone or accepted now
  assign aw_done = ~awvalid_q | m_awready_i;
  assign w_done  = ~wvalid_q | m_wready_i;
  assign rsp_hs  = (state_q == RD_DATA && m_rvalid_i) || (state_q == WR_RESP && m_bvalid_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= IDLE;
      grant_d_q <= 1'b0;
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
      arvalid_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          // load/store wins a tie
          if (d_req_i) begin
            grant_d_q <= 1'b1;
            if (d_we_i) begin
              state_q   <= WR_ADDR_DATA;
              awvalid_q <= 1'b1;
              wvalid_q  <= 1'b1;
            end else begin
              state_q   <= RD_ADDR;
              arvalid_q <= 1'b1;
            end
          end else if (f_req_i) begin
            grant_d_q <= 1'b0;
            state_q   <= RD_ADDR;
            arvalid_q <= 1'b1;
          end
        end
        RD_ADDR: begin
          if (m_arready_i) begin
            arvalid_q <= 1'b0;
            state_q   <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (m_rvalid_i) state_q <= IDLE;
        end
        WR_ADDR_DATA: begin
          if (m_awready_i) awvalid_q <= 1'b0;
          if (m_wready_i) wvalid_q <= 1'b0;
          if (aw_done && w_done) state_q <= WR_RESP;
        end
        WR_RESP: begin
          if (m_bvalid_i) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // fields of the granted request, held for the whole transaction
  always_ff @(posedge clk) begin
    if (state_q == IDLE) begin
      if (d_req_i) begin
        addr_q  <= d_addr_i;
        wdata_q <= d_wdata_i;
        wstrb_q <= d_wstrb_i;
      end else if (f_req_i) begin
        addr_q <= f_addr_i;
      end
    end
  end

  assign m_awvalid_o = awvalid_q;
  assign m_awaddr_o  = addr_q;
  assign m_wvalid_o  = wvalid_q;
  assign m_wdata_o   = wdata_q;
  assign m_wstrb_o   = wstrb_q;
  assign m_bready_o  = (state_q == WR_RESP);
  assign m_arvalid_o = arvalid_q;
  assign m_araddr_o  = addr_q;
  assign m_rready_o  = (state_q == RD_DATA);

  // ports register these on their done pulse
  assign bus_rdata_o = m_rdata_i;
  assign bus_err_o   = (state_q == WR_RESP) ? (m_bresp_i != OKAY) : (m_rresp_i != OKAY);
  assign d_done_o    = rsp_hs & grant_d_q;
  assign f_done_o    = rsp_hs & ~grant_d_q;

endmodule

`default_nettype wire

//--- verilog/lsu_port.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_port (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           lsu_valid_i,
  input  mem_op_pkg::mem_op_e            lsu_op_i,
  input  logic [bus_pkg::addr_width-1:0] lsu_addr_i,
  input  logic [mem_op_pkg::xlen-1:0]    lsu_wdata_i,
  output logic                           lsu_ready_o,
  output logic                           lsu_rsp_valid_o,
  output logic [mem_op_pkg::xlen-1:0]    lsu_rdata_o,
  output logic                           lsu_err_o,
  output logic                           d_req_o,
  output logic                           d_we_o,
  output logic [bus_pkg::addr_width-1:0] d_addr_o,
  output logic [bus_pkg::data_width-1:0] d_wdata_o,
  output logic [bus_pkg::strb_width-1:0] d_wstrb_o,
  input  logic                           d_done_i,
  input  logic [bus_pkg::data_width-1:0] bus_rdata_i,
  input  logic                           bus_err_i
);
  import bus_pkg::*;
  import mem_op_pkg::*;

  logic                  busy_q;
  logic                  req_q;
  logic                  rsp_valid_q;
  mem_op_e               op_q;
  logic [addr_width-1:0] addr_q;
  logic [xlen-1:0]       wdata_q;
  logic [xlen-1:0]       rdata_q;
  logic                  err_q;
  logic                  accept;
  logic [5:0]            shamt;
  logic [strb_width-1:0] size_mask;
  logic                  is_store;
  logic [data_width-1:0] rd_shifted;
  logic [xlen-1:0]       load_val;

  assign accept = lsu_valid_i & ~busy_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q      <= 1'b0;
      req_q       <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= d_done_i;
      if (accept) begin
        busy_q <= 1'b1;
        req_q  <= 1'b1;
      end else begin
        if (d_done_i) req_q <= 1'b0;
        if (rsp_valid_q) busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q    <= lsu_op_i;
      addr_q  <= lsu_addr_i;
      wdata_q <= lsu_wdata_i;
    end
    if (d_done_i) begin
      rdata_q <= load_val;
      err_q   <= bus_err_i;
    end
  end

  // byte offset in bits
  assign shamt = {addr_q[2:0], 3'b000};

  always_comb begin
    is_store  = 1'b1;
    size_mask = '0;
    case (op_q)
      SB: size_mask = 8'h01;
      SH: size_mask = 8'h03;
      SW: size_mask = 8'h0f;
      SD: size_mask = 8'hff;
      default: is_store = 1'b0;
    endcase
  end

  assign rd_shifted = bus_rdata_i >> shamt;

  // sign or zero extension by load type, stores give zero
  always_comb begin
    case (op_q)
      LB:  load_val = {{(xlen-8){rd_shifted[7]}}, rd_shifted[7:0]};
      LBU: load_val = {{(xlen-8){1'b0}}, rd_shifted[7:0]};
      LH:  load_val = {{(xlen-16){rd_shifted[15]}}, rd_shifted[15:0]};
      LHU: load_val = {{(xlen-16){1'b0}}, rd_shifted[15:0]};
      LW:  load_val = {{(xlen-32){rd_shifted[31]}}, rd_shifted[31:0]};
      LWU: load_val = {{(xlen-32){1'b0}}, rd_shifted[31:0]};
      LD:  load_val = rd_shifted[xlen-1:0];
      default: load_val = '0;
    endcase
  end

  assign lsu_ready_o     = ~busy_q;
  assign lsu_rsp_valid_o = rsp_valid_q;
  assign lsu_rdata_o     = rdata_q;
  assign lsu_err_o       = err_q;
  assign d_req_o         = req_q;
  assign d_we_o          = is_store;
  assign d_addr_o        = {addr_q[addr_width-1:3], 3'b000};
  assign d_wdata_o       = wdata_q << shamt;
  assign d_wstrb_o       = size_mask << addr_q[2:0];

endmodule

`default_nettype wire

//--- verilog/fetch_port.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_port (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             fetch_valid_i,
  input  logic [bus_pkg::addr_width-1:0]   fetch_pc_i,
  output logic                             fetch_ready_o,
  output logic                             fetch_rsp_valid_o,
  output logic [mem_op_pkg::inst_width-1:0] fetch_inst_o,
  output logic                             fetch_err_o,
  output logic                             f_req_o,
  output logic [bus_pkg::addr_width-1:0]   f_addr_o,
  input  logic                             f_done_i,
  input  logic [bus_pkg::data_width-1:0]   bus_rdata_i,
  input  logic                             bus_err_i
);
  import bus_pkg::*;
  import mem_op_pkg::*;

  logic                  busy_q;
  logic                  req_q;
  logic                  rsp_valid_q;
  logic [addr_width-1:0] pc_q;
  logic [inst_width-1:0] inst_q;
  logic                  err_q;
  logic                  accept;

  assign accept = fetch_valid_i & ~busy_q;

  // busy until the response pulse is out, req only until done
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q      <= 1'b0;
      req_q       <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= f_done_i;
      if (accept) begin
        busy_q <= 1'b1;
        req_q  <= 1'b1;
      end else begin
        if (f_done_i) req_q <= 1'b0;
        if (rsp_valid_q) busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) pc_q <= fetch_pc_i;
    if (f_done_i) begin
      // pc bit 2 picks the word half
      inst_q <= pc_q[2] ? bus_rdata_i[data_width-1:inst_width] : bus_rdata_i[inst_width-1:0];
      err_q  <= bus_err_i;
    end
  end

  assign fetch_ready_o     = ~busy_q;
  assign fetch_rsp_valid_o = rsp_valid_q;
  assign fetch_inst_o      = inst_q;
  assign fetch_err_o       = err_q;
  assign f_req_o           = req_q;
  assign f_addr_o          = {pc_q[addr_width-1:3], 3'b000};

endmodule

`default_nettype wire

//--- verilog/mem_op_pkg.sv
`default_nettype none

package mem_op_pkg;

  // core side widths
  localparam int xlen       = 64;
  localparam int inst_width = 32;

  // loads in the low half, stores from 4'h8 up
  typedef enum logic [3:0] {
    LB  = 4'h0,
    LBU = 4'h1,
    LH  = 4'h2,
    LHU = 4'h3,
    LW  = 4'h4,
    LWU = 4'h5,
    LD  = 4'h6,
    SB  = 4'h8,
    SH  = 4'h9,
    SW  = 4'ha,
    SD  = 4'hb
  } mem_op_e;

endpackage

`default_nettype wire

//--- verilog/bus_pkg.sv
`default_nettype none

package bus_pkg;

  // external master bus geometry
  localparam int addr_width = 32;
  localparam int data_width = 64;
  localparam int strb_width = data_width / 8;

  // anything but OKAY counts as an error
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // one transaction at a time on the master
  typedef enum logic [2:0] {
    IDLE         = 3'd0,
    RD_ADDR      = 3'd1,
    RD_DATA      = 3'd2,
    WR_ADDR_DATA = 3'd3,
    WR_RESP      = 3'd4
  } arb_state_e;

endpackage

`default_nettype wire
